//--- src/bru_params.svh
// Branch unit sizing: data width, reset PC, global history and counter table
`ifndef BRU_PARAMS_SVH
`define BRU_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

// Data and PC width
`define BRU_XLEN 32

// First fetch address after reset
`define BRU_PC_INIT 'h200

//////////////////////////////////////////////////
// Branch prediction
//////////////////////////////////////////////////

// Global history length in bits
`define BRU_BP_GLOBAL_BITS 2

// Counter table index width, 64 entries
`define BRU_BHT_BITS 6

`endif

//--- src/bru_pkg.sv
// Branch unit types: opcodes, branch functions, instruction word, exceptions
`default_nettype none

package bru_pkg;

  //////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////

  typedef logic [31:0] instr_t;

  // FENCE.I with rd, rs1 and imm all zero
  localparam instr_t FENCE_I_WORD = 32'h0000_100f;

  // Major opcodes seen by the branch unit
  typedef enum logic [6:0] {
    OPC_OTHER   = 7'b000_0000,
    OPC_MISCMEM = 7'b000_1111,
    OPC_BRANCH  = 7'b110_0011,
    OPC_JALR    = 7'b110_0111,
    OPC_JAL     = 7'b110_1111
  } opcode_e;

  //////////////////////////////////////////////////
  // Resolved branch function
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    BR_NONE    = 4'd0,
    BR_JAL     = 4'd1,
    BR_JALR    = 4'd2,
    BR_BEQ     = 4'd3,
    BR_BNE     = 4'd4,
    BR_BLT     = 4'd5,
    BR_BGE     = 4'd6,
    BR_BLTU    = 4'd7,
    BR_BGEU    = 4'd8,
    BR_FENCE_I = 4'd9,
    BR_FENCE   = 4'd10
  } br_func_e;

  // Exception bundle passed down the pipeline
  // any is the OR of the cause bits
  typedef struct packed {
    logic any;
    logic misaligned_instruction;
    logic illegal_instruction;
    logic breakpoint;
  } exceptions_t;

endpackage

`default_nettype wire

//--- src/bru_if.sv
// Branch unit internal buses: decoded fields, resolution result, predictor update
`timescale 1ns/100ps
`default_nettype none
`include "bru_params.svh"

// Decoder to resolver, combinational
interface bru_dec_if;
  bru_pkg::br_func_e    func;
  logic [`BRU_XLEN-1:0] imm_b;
  logic [`BRU_XLEN-1:0] imm_j;
  logic [`BRU_XLEN-1:0] pc_plus4;

  modport src (output func, imm_b, imm_j, pc_plus4);
  modport dst (input  func, imm_b, imm_j, pc_plus4);
endinterface

// Resolver to control, combinational
interface bru_res_if;
  logic                 btaken;
  logic                 bp_update;
  logic                 pipeflush;
  logic                 cacheflush;
  logic [`BRU_XLEN-1:0] nxt_pc;
  logic                 misaligned;

  modport src (output btaken, bp_update, pipeflush, cacheflush, nxt_pc, misaligned);
  modport dst (input  btaken, bp_update, pipeflush, cacheflush, nxt_pc, misaligned);
endinterface

// Control to counter table, update is a single cycle pulse
interface bru_upd_if;
  logic                           update;
  logic                           btaken;
  logic [`BRU_XLEN-1:0]           pc;
  logic [`BRU_BP_GLOBAL_BITS-1:0] history;

  modport src (output update, btaken, pc, history);
  modport dst (input  update, btaken, pc, history);
endinterface

`default_nettype wire

//--- src/bru_decode.sv
// Branch decoder: maps the ID instruction to a branch function and immediates
`timescale 1ns/100ps
`default_nettype none
`include "bru_params.svh"

module bru_decode (
  input  bru_pkg::instr_t      id_instr_i,
  input  logic                 id_bubble_i,
  input  logic [`BRU_XLEN-1:0] id_pc_i,
  bru_dec_if.src               dec
);

  bru_pkg::opcode_e opcode;
  logic [2:0]       funct3;

  assign funct3 = id_instr_i[14:12];

  // Fold unknown opcodes into OPC_OTHER
  always_comb begin
    case (id_instr_i[6:0])
      bru_pkg::OPC_JAL:     opcode = bru_pkg::OPC_JAL;
      bru_pkg::OPC_JALR:    opcode = bru_pkg::OPC_JALR;
      bru_pkg::OPC_BRANCH:  opcode = bru_pkg::OPC_BRANCH;
      bru_pkg::OPC_MISCMEM: opcode = bru_pkg::OPC_MISCMEM;
      default:              opcode = bru_pkg::OPC_OTHER;
    endcase
  end

  //////////////////////////////////////////////////
  // Branch function
  //////////////////////////////////////////////////

  always_comb begin
    dec.func = bru_pkg::BR_NONE;
    if (!id_bubble_i) begin
      case (opcode)
        bru_pkg::OPC_JAL:  dec.func = bru_pkg::BR_JAL;
        bru_pkg::OPC_JALR: dec.func = bru_pkg::BR_JALR;
        bru_pkg::OPC_BRANCH: begin
          case (funct3)
            3'b000:  dec.func = bru_pkg::BR_BEQ;
            3'b001:  dec.func = bru_pkg::BR_BNE;
            3'b100:  dec.func = bru_pkg::BR_BLT;
            3'b101:  dec.func = bru_pkg::BR_BGE;
            3'b110:  dec.func = bru_pkg::BR_BLTU;
            3'b111:  dec.func = bru_pkg::BR_BGEU;
            // 010 and 011 are reserved
            default: dec.func = bru_pkg::BR_NONE;
          endcase
        end
        // Only the exact FENCE.I word flushes the caches
        bru_pkg::OPC_MISCMEM: begin
          dec.func = (id_instr_i == bru_pkg::FENCE_I_WORD) ? bru_pkg::BR_FENCE_I
                                                           : bru_pkg::BR_FENCE;
        end
        default: dec.func = bru_pkg::BR_NONE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  // B-type, 13 bit offset with bit 0 always zero
  assign dec.imm_b = {{(`BRU_XLEN-12){id_instr_i[31]}}, id_instr_i[7],
                      id_instr_i[30:25], id_instr_i[11:8], 1'b0};

  // J-type, 21 bit offset with bit 0 always zero
  assign dec.imm_j = {{(`BRU_XLEN-20){id_instr_i[31]}}, id_instr_i[19:12],
                      id_instr_i[20], id_instr_i[30:21], 1'b0};

  // No compressed support, fall-through is always +4
  assign dec.pc_plus4 = id_pc_i + `BRU_XLEN'd4;

endmodule

`default_nettype wire

//--- src/bru_resolve.sv
// Branch resolver: compares operands, computes the target and the flush requests
`timescale 1ns/100ps
`default_nettype none
`include "bru_params.svh"

module bru_resolve (
  bru_dec_if.dst               dec,
  input  logic [`BRU_XLEN-1:0] id_pc_i,
  input  logic [`BRU_XLEN-1:0] opa_i,
  input  logic [`BRU_XLEN-1:0] opb_i,
  input  logic                 id_bp_taken_i,
  input  logic                 id_exc_misaligned_i,
  bru_res_if.src               res
);

  logic                 op_eq;
  logic                 op_lt;
  logic                 op_ltu;
  logic                 is_cond;
  logic                 cond_taken;
  logic [`BRU_XLEN-1:0] tgt_base;
  logic [`BRU_XLEN-1:0] tgt_ofs;
  logic [`BRU_XLEN-1:0] tgt_sum;
  logic [`BRU_XLEN-1:0] target;

  //////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////

  assign op_eq  = (opa_i == opb_i);
  assign op_lt  = ($signed(opa_i) < $signed(opb_i));
  assign op_ltu = (opa_i < opb_i);

  always_comb begin
    is_cond    = 1'b1;
    cond_taken = 1'b0;
    case (dec.func)
      bru_pkg::BR_BEQ:  cond_taken = op_eq;
      bru_pkg::BR_BNE:  cond_taken = ~op_eq;
      bru_pkg::BR_BLT:  cond_taken = op_lt;
      bru_pkg::BR_BGE:  cond_taken = ~op_lt;
      bru_pkg::BR_BLTU: cond_taken = op_ltu;
      bru_pkg::BR_BGEU: cond_taken = ~op_ltu;
      default:          is_cond    = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Target adder
  //////////////////////////////////////////////////

  // One shared adder, JALR adds the operands, everything else adds to PC
  always_comb begin
    tgt_base = id_pc_i;
    tgt_ofs  = dec.imm_b;
    case (dec.func)
      bru_pkg::BR_JAL: tgt_ofs = dec.imm_j;
      bru_pkg::BR_JALR: begin
        tgt_base = opa_i;
        tgt_ofs  = opb_i;
      end
      default: tgt_ofs = dec.imm_b;
    endcase
  end

  assign tgt_sum = tgt_base + tgt_ofs;

  // JALR drops bit 0 of the sum
  assign target = (dec.func == bru_pkg::BR_JALR) ? {tgt_sum[`BRU_XLEN-1:1], 1'b0} : tgt_sum;

  //////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////

  always_comb begin
    res.btaken     = cond_taken;
    res.bp_update  = is_cond;
    res.cacheflush = 1'b0;
    // Mispredict on conditional branches, no flush otherwise
    res.pipeflush  = is_cond & (cond_taken ^ id_bp_taken_i);
    case (dec.func)
      bru_pkg::BR_JAL: begin
        res.btaken    = 1'b1;
        // Fetch already redirected when predicted
        res.pipeflush = ~id_bp_taken_i;
      end
      bru_pkg::BR_JALR: begin
        res.btaken    = 1'b1;
        res.pipeflush = 1'b1;
      end
      bru_pkg::BR_FENCE_I: begin
        res.pipeflush  = 1'b1;
        res.cacheflush = 1'b1;
      end
      default: ;
    endcase
  end

  assign res.nxt_pc = res.btaken ? target : dec.pc_plus4;

  // Word alignment check on computed targets only
  assign res.misaligned = id_exc_misaligned_i |
                          ((is_cond || dec.func == bru_pkg::BR_JALR) && (|res.nxt_pc[1:0]));

endmodule

`default_nettype wire

//--- src/bru_ctrl.sv
// Branch control: registers the resolution, squashes exceptions, keeps global history
`timescale 1ns/100ps
`default_nettype none
`include "bru_params.svh"

module bru_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           ex_stall_i,
  input  logic                           st_flush_i,
  input  logic                           later_exc_any_i,
  input  logic [`BRU_XLEN-1:0]           id_pc_i,
  input  logic [1:0]                     id_bp_predict_i,
  input  bru_pkg::exceptions_t           id_exc_i,
  bru_res_if.dst                         res,
  bru_upd_if.src                         upd,
  output logic [`BRU_XLEN-1:0]           bu_nxt_pc_o,
  output logic                           bu_flush_o,
  output logic                           bu_cacheflush_o,
  output logic [1:0]                     bu_bp_predict_o,
  output logic                           bu_bp_btaken_o,
  output logic                           bu_bp_update_o,
  output logic [`BRU_BP_GLOBAL_BITS-1:0] bu_bp_history_o,
  output bru_pkg::exceptions_t           bu_exceptions_o
);

  // One extra bit holds the branch just resolved
  logic [`BRU_BP_GLOBAL_BITS:0] bp_history_q;
  logic [`BRU_XLEN-1:0]         upd_pc_q;
  bru_pkg::exceptions_t         exc_d;
  logic                         squash;

  //////////////////////////////////////////////////
  // Flush and prediction feedback
  //////////////////////////////////////////////////

  // These ignore the stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Start with the pipeline flushed
      bu_flush_o      <= 1'b1;
      bu_cacheflush_o <= 1'b0;
      bu_bp_predict_o <= 2'b00;
      bu_bp_btaken_o  <= 1'b0;
      bu_bp_update_o  <= 1'b0;
      bp_history_q    <= '0;
    end else begin
      bu_flush_o      <= res.pipeflush;
      bu_cacheflush_o <= res.cacheflush;
      bu_bp_predict_o <= id_bp_predict_i;
      bu_bp_btaken_o  <= res.btaken;
      bu_bp_update_o  <= res.bp_update;
      // Shift register of taken bits, conditional branches only
      if (res.bp_update) begin
        bp_history_q <= {bp_history_q[`BRU_BP_GLOBAL_BITS-1:0], res.btaken};
      end
    end
  end

  // Newest bit left out so a branch does not see itself
  assign bu_bp_history_o = bp_history_q[`BRU_BP_GLOBAL_BITS:1];

  // Branch PC for training, valid together with bu_bp_update_o
  always_ff @(posedge clk_i) begin
    if (res.bp_update) begin
      upd_pc_q <= id_pc_i;
    end
  end

  assign upd.update  = bu_bp_update_o;
  assign upd.btaken  = bu_bp_btaken_o;
  assign upd.pc      = upd_pc_q;
  assign upd.history = bu_bp_history_o;

  //////////////////////////////////////////////////
  // Next PC and exceptions
  //////////////////////////////////////////////////

  // Wrong-path instruction or an older stage already trapping
  assign squash = bu_flush_o | st_flush_i | later_exc_any_i;

  always_comb begin
    exc_d                        = id_exc_i;
    exc_d.misaligned_instruction = res.misaligned;
    exc_d.any                    = id_exc_i.any | res.misaligned;
  end

  // Frozen while EX stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bu_nxt_pc_o     <= `BRU_XLEN'(`BRU_PC_INIT);
      bu_exceptions_o <= '0;
    end else if (!ex_stall_i) begin
      bu_nxt_pc_o     <= res.nxt_pc;
      bu_exceptions_o <= squash ? '0 : exc_d;
    end
  end

endmodule

`default_nettype wire

//--- src/bru_bht.sv
// Branch history table: 2-bit saturating counters indexed by PC xor global history
`timescale 1ns/100ps
`default_nettype none
`include "bru_params.svh"

module bru_bht (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [`BRU_XLEN-1:0]           fetch_pc_i,
  input  logic [`BRU_BP_GLOBAL_BITS-1:0] history_i,
  bru_upd_if.dst                         upd,
  output logic [1:0]                     fetch_predict_o
);

  localparam int unsigned NUM_ENTRIES = 1 << `BRU_BHT_BITS;

  logic [NUM_ENTRIES-1:0][1:0] cnt_q;
  logic [`BRU_BHT_BITS-1:0]    fetch_idx;
  logic [`BRU_BHT_BITS-1:0]    upd_idx;
  logic [1:0]                  upd_cnt;
  logic [1:0]                  upd_cnt_nxt;

  // Word address bits hashed with the zero-extended history
  function automatic logic [`BRU_BHT_BITS-1:0] bht_index(
    input logic [`BRU_XLEN-1:0]           pc,
    input logic [`BRU_BP_GLOBAL_BITS-1:0] hist
  );
    return pc[`BRU_BHT_BITS+1:2] ^
           {{(`BRU_BHT_BITS-`BRU_BP_GLOBAL_BITS){1'b0}}, hist};
  endfunction

  assign fetch_idx = bht_index(fetch_pc_i, history_i);
  assign upd_idx   = bht_index(upd.pc, upd.history);

  //////////////////////////////////////////////////
  // Training
  //////////////////////////////////////////////////

  assign upd_cnt = cnt_q[upd_idx];

  // Saturate at strongly taken and strongly not taken
  always_comb begin
    upd_cnt_nxt = upd_cnt;
    if (upd.btaken && upd_cnt != 2'b11) begin
      upd_cnt_nxt = upd_cnt + 2'd1;
    end else if (!upd.btaken && upd_cnt != 2'b00) begin
      upd_cnt_nxt = upd_cnt - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Every entry weakly not taken
      cnt_q <= {NUM_ENTRIES{2'b01}};
    end else if (upd.update) begin
      cnt_q[upd_idx] <= upd_cnt_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////

  // Reads the table before this edge's training takes effect
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_predict_o <= 2'b01;
    end else begin
      fetch_predict_o <= cnt_q[fetch_idx];
    end
  end

endmodule

`default_nettype wire

//--- src/bru_top.sv
// Branch resolution unit top: decoder, resolver, control and counter table
`timescale 1ns/100ps
`default_nettype none
`include "bru_params.svh"

module bru_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Pipeline control
  input  logic                           ex_stall_i,
  input  logic                           st_flush_i,
  input  logic                           later_exc_any_i,
  // Decoded instruction from ID
  input  bru_pkg::instr_t                id_instr_i,
  input  logic                           id_bubble_i,
  input  logic [`BRU_XLEN-1:0]           id_pc_i,
  input  logic [`BRU_XLEN-1:0]           opa_i,
  input  logic [`BRU_XLEN-1:0]           opb_i,
  input  logic [1:0]                     id_bp_predict_i,
  input  bru_pkg::exceptions_t           id_exc_i,
  // Fetch side prediction
  input  logic [`BRU_XLEN-1:0]           fetch_pc_i,
  output logic [1:0]                     fetch_predict_o,
  // Toward EX
  output logic [`BRU_XLEN-1:0]           bu_nxt_pc_o,
  output logic                           bu_flush_o,
  output logic                           bu_cacheflush_o,
  output logic [1:0]                     bu_bp_predict_o,
  output logic                           bu_bp_btaken_o,
  output logic                           bu_bp_update_o,
  output logic [`BRU_BP_GLOBAL_BITS-1:0] bu_bp_history_o,
  output bru_pkg::exceptions_t           bu_exceptions_o
);

  bru_dec_if dec_if ();
  bru_res_if res_if ();
  bru_upd_if upd_if ();

  bru_decode u_decode (
    .id_instr_i  (id_instr_i),
    .id_bubble_i (id_bubble_i),
    .id_pc_i     (id_pc_i),
    .dec         (dec_if.src)
  );

  // Bit 1 of the prediction is the taken guess
  bru_resolve u_resolve (
    .dec                 (dec_if.dst),
    .id_pc_i             (id_pc_i),
    .opa_i               (opa_i),
    .opb_i               (opb_i),
    .id_bp_taken_i       (id_bp_predict_i[1]),
    .id_exc_misaligned_i (id_exc_i.misaligned_instruction),
    .res                 (res_if.src)
  );

  bru_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ex_stall_i      (ex_stall_i),
    .st_flush_i      (st_flush_i),
    .later_exc_any_i (later_exc_any_i),
    .id_pc_i         (id_pc_i),
    .id_bp_predict_i (id_bp_predict_i),
    .id_exc_i        (id_exc_i),
    .res             (res_if.dst),
    .upd             (upd_if.src),
    .bu_nxt_pc_o     (bu_nxt_pc_o),
    .bu_flush_o      (bu_flush_o),
    .bu_cacheflush_o (bu_cacheflush_o),
    .bu_bp_predict_o (bu_bp_predict_o),
    .bu_bp_btaken_o  (bu_bp_btaken_o),
    .bu_bp_update_o  (bu_bp_update_o),
    .bu_bp_history_o (bu_bp_history_o),
    .bu_exceptions_o (bu_exceptions_o)
  );

  bru_bht u_bht (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_pc_i      (fetch_pc_i),
    .history_i       (bu_bp_history_o),
    .upd             (upd_if.dst),
    .fetch_predict_o (fetch_predict_o)
  );

endmodule

`default_nettype wire

//--- verification/bru_chk.sv
// Branch unit checker: concurrent assertions on the top-level outputs
`timescale 1ns/100ps
`default_nettype none
`include "bru_params.svh"

module bru_chk (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 ex_stall_i,
  input logic                 bu_flush_o,
  input logic                 bu_cacheflush_o,
  input logic                 bu_bp_update_o,
  input logic [`BRU_XLEN-1:0] bu_nxt_pc_o
);

  // A cache flush always restarts the pipeline too
  a_cacheflush_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bu_cacheflush_o |-> bu_flush_o)
    else $error("cache flush raised without pipeline flush");

  // No predictor training while in reset
  a_no_update_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !bu_bp_update_o)
    else $error("predictor update raised during reset");

  // Next PC frozen by a stalled EX stage
  a_stall_holds_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_stall_i |=> $stable(bu_nxt_pc_o))
    else $error("next PC changed across a stall");

endmodule

bind bru_top bru_chk u_chk (.*);

`default_nettype wire

//--- verification/bru_tb.sv
// Branch unit testbench: random and directed stimulus against a reference model
`timescale 1ns/100ps
`default_nettype none
`include "bru_params.svh"

module bru_tb;

  localparam int STIM_TOTAL  = 560;
  localparam int CYCLE_LIMIT = 20 * STIM_TOTAL;

  // Reference result of one resolved instruction
  typedef struct packed {
    logic        taken;
    logic        flush;
    logic        cflush;
    logic        upd;
    logic        mis;
    logic [31:0] nxt_pc;
  } res_t;

  // Expected outputs one cycle after a drive
  typedef struct packed {
    logic [31:0] nxt_pc;
    logic        flush;
    logic        cflush;
    logic        btaken;
    logic        upd;
    logic [1:0]  pred;
    logic [1:0]  bp_pred;
    logic [1:0]  hist;
    logic [3:0]  exc;
  } exp_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 ex_stall_i;
  logic                 st_flush_i;
  logic                 later_exc_any_i;
  bru_pkg::instr_t      id_instr_i;
  logic                 id_bubble_i;
  logic [31:0]          id_pc_i;
  logic [31:0]          opa_i;
  logic [31:0]          opb_i;
  logic [1:0]           id_bp_predict_i;
  bru_pkg::exceptions_t id_exc_i;
  logic [31:0]          fetch_pc_i;
  logic [1:0]           fetch_predict_o;
  logic [31:0]          bu_nxt_pc_o;
  logic                 bu_flush_o;
  logic                 bu_cacheflush_o;
  logic [1:0]           bu_bp_predict_o;
  logic                 bu_bp_btaken_o;
  logic                 bu_bp_update_o;
  logic [1:0]           bu_bp_history_o;
  bru_pkg::exceptions_t bu_exceptions_o;

  integer seed = 69;
  int     errors = 0;
  int     err_start = 0;
  int     tests_pass = 0;
  int     tests_fail = 0;
  int     cycles = 0;
  int     n_due = 0;
  string  cur_test = "none";
  exp_t   exp_q[$];
  exp_t   ce;

  // Model state, as seen after the last modeled edge
  logic [1:0]  cnt_m [64];
  logic [2:0]  hist_m = 3'b000;
  logic [31:0] pc_m = 32'h200;
  logic [3:0]  exc_m = 4'b0;
  logic        flush_m = 1'b1;
  logic        pend_upd = 1'b0;
  logic        pend_taken = 1'b0;
  logic [5:0]  pend_idx = 6'd0;

  bru_top dut (.*);

  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic res_t ref_resolve(input bru_pkg::br_func_e f, input logic [31:0] pc,
                                       input logic [31:0] imm, input logic [31:0] a,
                                       input logic [31:0] b, input logic pt, input logic mis_in);
    res_t r;
    logic cond;
    cond = f inside {bru_pkg::BR_BEQ, bru_pkg::BR_BNE, bru_pkg::BR_BLT,
                     bru_pkg::BR_BGE, bru_pkg::BR_BLTU, bru_pkg::BR_BGEU};
    case (f)
      bru_pkg::BR_BEQ:  r.taken = (a == b);
      bru_pkg::BR_BNE:  r.taken = (a != b);
      bru_pkg::BR_BLT:  r.taken = ($signed(a) < $signed(b));
      bru_pkg::BR_BGE:  r.taken = ($signed(a) >= $signed(b));
      bru_pkg::BR_BLTU: r.taken = (a < b);
      bru_pkg::BR_BGEU: r.taken = (a >= b);
      bru_pkg::BR_JAL:  r.taken = 1'b1;
      bru_pkg::BR_JALR: r.taken = 1'b1;
      default:          r.taken = 1'b0;
    endcase
    if (!r.taken) r.nxt_pc = pc + 32'd4;
    else if (f == bru_pkg::BR_JALR) r.nxt_pc = (a + b) & 32'hffff_fffe;
    else r.nxt_pc = pc + imm;
    // Mispredict for branches, unpredicted JAL, always for JALR and FENCE.I
    if (cond) r.flush = r.taken ^ pt;
    else if (f == bru_pkg::BR_JAL) r.flush = !pt;
    else r.flush = (f == bru_pkg::BR_JALR) || (f == bru_pkg::BR_FENCE_I);
    r.cflush = (f == bru_pkg::BR_FENCE_I);
    r.upd    = cond;
    r.mis    = mis_in | ((cond || f == bru_pkg::BR_JALR) && (r.nxt_pc[1:0] != 2'b00));
    return r;
  endfunction

  function automatic logic [5:0] bht_slot(input logic [31:0] pc, input logic [1:0] h);
    return pc[7:2] ^ {4'b0000, h};
  endfunction

  function automatic logic [1:0] train(input logic [1:0] c, input logic t);
    if (t && c != 2'b11) return c + 2'd1;
    if (!t && c != 2'b00) return c - 2'd1;
    return c;
  endfunction

  // Builds the instruction word for a branch function
  function automatic logic [31:0] encode(input bru_pkg::br_func_e f, input logic [31:0] imm);
    logic [2:0] f3;
    case (f)
      bru_pkg::BR_BNE:  f3 = 3'b001;
      bru_pkg::BR_BLT:  f3 = 3'b100;
      bru_pkg::BR_BGE:  f3 = 3'b101;
      bru_pkg::BR_BLTU: f3 = 3'b110;
      bru_pkg::BR_BGEU: f3 = 3'b111;
      default:          f3 = 3'b000;
    endcase
    case (f)
      bru_pkg::BR_JAL:
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b110_1111};
      bru_pkg::BR_JALR:
        return {12'h000, 5'd1, 3'b000, 5'd1, 7'b110_0111};
      bru_pkg::BR_BEQ, bru_pkg::BR_BNE, bru_pkg::BR_BLT,
      bru_pkg::BR_BGE, bru_pkg::BR_BLTU, bru_pkg::BR_BGEU:
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b110_0011};
      bru_pkg::BR_FENCE_I: return bru_pkg::FENCE_I_WORD;
      bru_pkg::BR_FENCE:   return 32'h0ff0_000f;
      default:             return 32'h0000_0013;
    endcase
  endfunction

  // Corner values, a copy of the other operand, or random
  function automatic logic [31:0] pick_operand(input logic [31:0] other);
    int sel;
    sel = {$random(seed)} % 6;
    case (sel)
      0:       return 32'h7fff_ffff;
      1:       return 32'h8000_0000;
      2:       return 32'hffff_ffff;
      3:       return 32'h0000_0000;
      4:       return other;
      default: return $random(seed);
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Drives one instruction and queues what the outputs must show after the next edge
  task automatic step(input bru_pkg::br_func_e f, input logic [31:0] imm,
                      input logic [31:0] pc, input logic [31:0] a, input logic [31:0] b,
                      input logic [1:0] pred, input logic [3:0] exc, input logic bubble,
                      input logic stall, input logic stf, input logic later,
                      input logic [31:0] fpc);
    res_t              r;
    exp_t              e;
    bru_pkg::br_func_e fe;
    logic              squash;
    fe = bubble ? bru_pkg::BR_NONE : f;
    id_instr_i      <= encode(f, imm);
    id_bubble_i     <= bubble;
    id_pc_i         <= pc;
    opa_i           <= a;
    opb_i           <= b;
    id_bp_predict_i <= pred;
    id_exc_i        <= bru_pkg::exceptions_t'(exc);
    ex_stall_i      <= stall;
    st_flush_i      <= stf;
    later_exc_any_i <= later;
    fetch_pc_i      <= fpc;
    r = ref_resolve(fe, pc, imm, a, b, pred[1], exc[2]);
    // Lookup sees the table before the previous branch trains it
    e.pred = cnt_m[bht_slot(fpc, hist_m[2:1])];
    if (pend_upd) cnt_m[pend_idx] = train(cnt_m[pend_idx], pend_taken);
    pend_upd   = r.upd;
    pend_idx   = bht_slot(pc, hist_m[1:0]);
    pend_taken = r.taken;
    if (r.upd) hist_m = {hist_m[1:0], r.taken};
    squash = flush_m | stf | later;
    if (!stall) begin
      pc_m  = r.nxt_pc;
      exc_m = squash ? 4'b0000 : {exc[3] | r.mis, r.mis, exc[1:0]};
    end
    flush_m   = r.flush;
    e.nxt_pc  = pc_m;
    e.flush   = r.flush;
    e.cflush  = r.cflush;
    e.btaken  = r.taken;
    e.upd     = r.upd;
    e.bp_pred = pred;
    e.hist    = hist_m[2:1];
    e.exc     = exc_m;
    exp_q.push_back(e);
    @(posedge clk_i);
  endtask

  task automatic rand_step(input bru_pkg::br_func_e f, input logic ctrl);
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ctl;
    r   = $random(seed);
    imm = (f == bru_pkg::BR_JAL) ? {{11{r[20]}}, r[20:1], 1'b0} : {{19{r[12]}}, r[12:1], 1'b0};
    pc  = $random(seed) & 32'hffff_fffc;
    a   = pick_operand($random(seed));
    b   = pick_operand(a);
    ctl = ctrl ? $random(seed) : 32'h0;
    step(f, imm, pc, a, b, r[31:30], ctl[3:0], ctl[4] & ctl[7], ctl[5] & ctl[6],
         ctl[8] & ctl[9], ctl[10] & ctl[11], $random(seed));
  endtask

  task automatic idle_step();
    step(bru_pkg::BR_NONE, 32'h0, 32'h100, 32'h0, 32'h0, 2'b00, 4'h0, 1'b1, 1'b0, 1'b0,
         1'b0, 32'h100);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  // Two bubbles let the last check land before the verdict
  task automatic end_test();
    idle_step();
    idle_step();
    if (errors == err_start) begin
      tests_pass++;
      $display("Test %s passed", cur_test);
    end else begin
      tests_fail++;
      $display("Test %s failed with %0d mismatches", cur_test, errors - err_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic check_val(input string what, input logic [31:0] expv, input logic [31:0] act);
    if (expv !== act) begin
      errors++;
      $display("[FAIL] %s %s expected %h actual %h", cur_test, what, expv, act);
    end
  endtask

  // Entries queued before the previous negedge have been sampled by now
  always @(negedge clk_i) begin
    for (int i = 0; i < n_due; i++) begin
      ce = exp_q.pop_front();
      check_val("nxt_pc", ce.nxt_pc, bu_nxt_pc_o);
      check_val("flush", 32'(ce.flush), 32'(bu_flush_o));
      check_val("cacheflush", 32'(ce.cflush), 32'(bu_cacheflush_o));
      check_val("btaken", 32'(ce.btaken), 32'(bu_bp_btaken_o));
      check_val("update", 32'(ce.upd), 32'(bu_bp_update_o));
      check_val("bp_predict", 32'(ce.bp_pred), 32'(bu_bp_predict_o));
      check_val("history", 32'(ce.hist), 32'(bu_bp_history_o));
      check_val("exceptions", {28'h0, ce.exc}, {28'h0, bu_exceptions_o});
      check_val("fetch_predict", 32'(ce.pred), 32'(fetch_predict_o));
    end
    n_due = exp_q.size();
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    ex_stall_i      = 1'b0;
    st_flush_i      = 1'b0;
    later_exc_any_i = 1'b0;
    id_instr_i      = 32'h0000_0013;
    id_bubble_i     = 1'b1;
    id_pc_i         = 32'h100;
    opa_i           = 32'h0;
    opb_i           = 32'h0;
    id_bp_predict_i = 2'b00;
    id_exc_i        = '0;
    fetch_pc_i      = 32'h100;
    for (int i = 0; i < 64; i++) cnt_m[i] = 2'b01;

    start_test("reset");
    repeat (15) @(posedge clk_i);
    @(negedge clk_i);
    check_val("flush", 32'd1, 32'(bu_flush_o));
    check_val("cacheflush", 32'd0, 32'(bu_cacheflush_o));
    check_val("update", 32'd0, 32'(bu_bp_update_o));
    check_val("btaken", 32'd0, 32'(bu_bp_btaken_o));
    check_val("nxt_pc", 32'h200, bu_nxt_pc_o);
    check_val("exceptions", 32'd0, {28'h0, bu_exceptions_o});
    @(posedge clk_i);
    rst_ni <= 1'b1;
    end_test();

    start_test("cond_branch");
    for (int i = 0; i < 300; i++) begin
      rand_step(bru_pkg::br_func_e'(4'(3 + ({$random(seed)} % 6))), 1'b0);
    end
    end_test();

    start_test("jal_jalr");
    for (int i = 0; i < 20; i++) rand_step(bru_pkg::BR_JAL, 1'b0);
    // Bubble ahead of each JALR so its misaligned exception is not squashed
    for (int i = 0; i < 20; i++) begin
      idle_step();
      rand_step(bru_pkg::BR_JALR, 1'b0);
    end
    end_test();

    start_test("fence_bubble");
    for (int i = 0; i < 3; i++) rand_step(bru_pkg::BR_FENCE_I, 1'b0);
    for (int i = 0; i < 3; i++) rand_step(bru_pkg::BR_FENCE, 1'b0);
    step(bru_pkg::BR_JALR, 32'h0, 32'h400, 32'h800, 32'h4, 2'b11, 4'h0, 1'b1, 1'b0, 1'b0,
         1'b0, 32'h400);
    step(bru_pkg::BR_BEQ, 32'h10, 32'h404, 32'h5, 32'h5, 2'b00, 4'h0, 1'b1, 1'b0, 1'b0,
         1'b0, 32'h404);
    end_test();

    start_test("stall_squash");
    for (int i = 0; i < 80; i++) begin
      rand_step(bru_pkg::br_func_e'(4'({$random(seed)} % 11)), 1'b1);
    end
    end_test();

    start_test("history_predict");
    for (int i = 0; i < 6; i++) begin
      step(bru_pkg::BR_BEQ, 32'd16, 32'h1000, 32'd5, 32'd5, 2'b00, 4'h0, 1'b0, 1'b0, 1'b0,
           1'b0, 32'h1000);
    end
    for (int i = 0; i < 6; i++) begin
      step(bru_pkg::BR_BNE, 32'd16, 32'h1000, 32'd5, 32'd5, 2'b00, 4'h0, 1'b0, 1'b0, 1'b0,
           1'b0, 32'h1000);
    end
    for (int i = 0; i < 40; i++) begin
      rand_step(bru_pkg::br_func_e'(4'(3 + ({$random(seed)} % 6))), 1'b0);
    end
    end_test();

    $display("Tests passed: %0d, failed: %0d, mismatches: %0d", tests_pass, tests_fail,
             errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/bru_pkg.sv
src/bru_if.sv
src/bru_decode.sv
src/bru_resolve.sv
src/bru_ctrl.sv
src/bru_bht.sv
src/bru_top.sv
verification/bru_chk.sv
verification/bru_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide the verdict from the simulation log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module bru_tb -o bru_sim &&
./obj_dir/bru_sim | tee sim.log &&
grep -q "Simulation completed successfully" sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
